//--- Bender.yml
package:
  name: riscv_core

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/riscv_core_pkg.sv
      - rtl/riscv_fetch.sv
      - rtl/riscv_decode.sv
      - rtl/riscv_execute.sv
      - rtl/riscv_mem_wb.sv
      - rtl/riscv_hazard.sv
      - rtl/riscv_core.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/riscv_core_tb.sv

//--- rtl/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
  input  logic                  i_riscv_core_clk,
  input  logic                  i_rst_n,
  input  riscv_core_pkg::inst_t i_imem_inst,
  input  riscv_core_pkg::xlen_t i_dmem_rdata,
  output riscv_core_pkg::xlen_t o_imem_addr,
  output riscv_core_pkg::xlen_t o_dmem_addr,
  output riscv_core_pkg::xlen_t o_dmem_wdata,
  output logic                  o_dmem_we,
  output logic                  o_dmem_re
);

  riscv_core_pkg::xlen_t     pc_d;
  riscv_core_pkg::inst_t     inst_d;
  riscv_core_pkg::reg_addr_t rs1_d;
  riscv_core_pkg::reg_addr_t rs2_d;
  riscv_core_pkg::de_reg_t   de;
  riscv_core_pkg::em_reg_t   em;
  logic                      redirect;
  riscv_core_pkg::xlen_t     target;
  riscv_core_pkg::xlen_t     mem_result;
  logic                      wb_we;
  riscv_core_pkg::reg_addr_t wb_rd;
  riscv_core_pkg::xlen_t     wb_data;
  logic                      stall;
  logic                      flush_fd;
  logic                      flush_de;
  riscv_core_pkg::fwd_sel_e  fwd_a;
  riscv_core_pkg::fwd_sel_e  fwd_b;

  riscv_fetch u_fetch (
    .i_riscv_fetch_clk (i_riscv_core_clk),
    .i_rst_n           (i_rst_n),
    .i_stall           (stall),
    .i_flush           (flush_fd),
    .i_redirect        (redirect),
    .i_target          (target),
    .i_inst            (i_imem_inst),
    .o_pc              (o_imem_addr),
    .o_pc_d            (pc_d),
    .o_inst_d          (inst_d)
  );

  riscv_decode u_decode (
    .i_riscv_decode_clk (i_riscv_core_clk),
    .i_rst_n            (i_rst_n),
    .i_flush            (flush_de),
    .i_stall            (stall),
    .i_inst             (inst_d),
    .i_pc               (pc_d),
    .i_wb_we            (wb_we),
    .i_wb_rd            (wb_rd),
    .i_wb_data          (wb_data),
    .o_rs1              (rs1_d),
    .o_rs2              (rs2_d),
    .o_de               (de)
  );

  riscv_execute u_execute (
    .i_riscv_execute_clk (i_riscv_core_clk),
    .i_rst_n             (i_rst_n),
    .i_de                (de),
    .i_fwd_a             (fwd_a),
    .i_fwd_b             (fwd_b),
    .i_mem_result        (mem_result),
    .i_wb_result         (wb_data),
    .o_redirect          (redirect),
    .o_target            (target),
    .o_em                (em)
  );

  riscv_mem_wb u_mem_wb (
    .i_riscv_mem_wb_clk (i_riscv_core_clk),
    .i_rst_n            (i_rst_n),
    .i_em               (em),
    .i_dmem_rdata       (i_dmem_rdata),
    .o_dmem_addr        (o_dmem_addr),
    .o_dmem_wdata       (o_dmem_wdata),
    .o_dmem_we          (o_dmem_we),
    .o_dmem_re          (o_dmem_re),
    .o_mem_result       (mem_result),
    .o_wb_we            (wb_we),
    .o_wb_rd            (wb_rd),
    .o_wb_data          (wb_data)
  );

  riscv_hazard u_hazard (
    .i_rs1_d       (rs1_d),
    .i_rs2_d       (rs2_d),
    .i_rs1_e       (de.rs1),
    .i_rs2_e       (de.rs2),
    .i_rd_e        (de.rd),
    .i_rd_m        (em.rd),
    .i_rd_w        (wb_rd),
    .i_mem_read_e  (de.ctrl.mem_read),
    .i_reg_write_m (em.reg_write),
    .i_reg_write_w (wb_we),
    .i_redirect    (redirect),
    .o_stall       (stall),
    .o_flush_fd    (flush_fd),
    .o_flush_de    (flush_de),
    .o_fwd_a       (fwd_a),
    .o_fwd_b       (fwd_b)
  );

endmodule

`default_nettype wire

//--- rtl/riscv_core_defines.svh
`ifndef RISCV_CORE_DEFINES_SVH
`define RISCV_CORE_DEFINES_SVH

`define XLEN     64
`define NUM_REGS 32
`define RESET_PC 64'h0000_0000_0000_0000  // first fetch address

// major opcodes, inst[6:0]
`define OPC_OP     7'b0110011  // add sub and or xor
`define OPC_OP_IMM 7'b0010011  // addi
`define OPC_LUI    7'b0110111
`define OPC_LOAD   7'b0000011  // ld
`define OPC_STORE  7'b0100011  // sd
`define OPC_BRANCH 7'b1100011  // beq bne
`define OPC_JAL    7'b1101111

`endif

//--- rtl/riscv_core_pkg.sv
`default_nettype none
`include "riscv_core_defines.svh"

package riscv_core_pkg;

  typedef logic [`XLEN-1:0]              xlen_t;
  typedef logic [31:0]                   inst_t;
  typedef logic [$clog2(`NUM_REGS)-1:0]  reg_addr_t;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_PASS_B = 3'd5   // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    RES_ALU  = 2'd0,
    RES_LOAD = 2'd1,
    RES_LINK = 2'd2     // pc+4 for jal
  } result_src_e;

  typedef enum logic [1:0] {
    FWD_REG = 2'd0,
    FWD_MEM = 2'd1,
    FWD_WB  = 2'd2
  } fwd_sel_e;

  typedef struct packed {
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        branch;
    logic        branch_ne;  // bne when set, beq otherwise
    logic        jump;
    logic        use_imm;
    alu_op_e     alu_op;
    result_src_e result_src;
  } ctrl_t;

  typedef struct packed {
    ctrl_t     ctrl;
    xlen_t     pc;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     imm;
  } de_reg_t;

  typedef struct packed {
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    result_src_e result_src;
    xlen_t       alu_result;
    xlen_t       store_data;
    xlen_t       pc_plus4;
    reg_addr_t   rd;
  } em_reg_t;

  typedef struct packed {
    logic        reg_write;
    result_src_e result_src;
    xlen_t       alu_result;
    xlen_t       load_data;
    xlen_t       pc_plus4;
    reg_addr_t   rd;
  } mw_reg_t;

endpackage

`default_nettype wire

//--- rtl/riscv_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_core_defines.svh"

module riscv_decode (
  input  logic                        i_riscv_decode_clk,
  input  logic                        i_rst_n,
  input  logic                        i_flush,
  input  logic                        i_stall,
  input  riscv_core_pkg::inst_t       i_inst,
  input  riscv_core_pkg::xlen_t       i_pc,
  input  logic                        i_wb_we,
  input  riscv_core_pkg::reg_addr_t   i_wb_rd,
  input  riscv_core_pkg::xlen_t       i_wb_data,
  output riscv_core_pkg::reg_addr_t   o_rs1,
  output riscv_core_pkg::reg_addr_t   o_rs2,
  output riscv_core_pkg::de_reg_t     o_de
);

  riscv_core_pkg::xlen_t     regs [`NUM_REGS];
  riscv_core_pkg::ctrl_t     ctrl;
  riscv_core_pkg::xlen_t     imm;
  riscv_core_pkg::xlen_t     rs1_data;
  riscv_core_pkg::xlen_t     rs2_data;
  riscv_core_pkg::reg_addr_t rd;
  logic [6:0]                opcode;
  logic [2:0]                funct3;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign rd     = i_inst[11:7];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  always_comb begin
    ctrl = '0;  // nop unless recognised
    case (opcode)
      `OPC_OP: begin
        ctrl.reg_write = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = i_inst[30] ? riscv_core_pkg::ALU_SUB : riscv_core_pkg::ALU_ADD;
          3'b100:  ctrl.alu_op = riscv_core_pkg::ALU_XOR;
          3'b110:  ctrl.alu_op = riscv_core_pkg::ALU_OR;
          3'b111:  ctrl.alu_op = riscv_core_pkg::ALU_AND;
          default: ctrl.reg_write = 1'b0;  // shifts and compares not kept
        endcase
      end
      `OPC_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
      end
      `OPC_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.alu_op    = riscv_core_pkg::ALU_PASS_B;
      end
      `OPC_LOAD: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.use_imm    = 1'b1;
        ctrl.result_src = riscv_core_pkg::RES_LOAD;
      end
      `OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.use_imm   = 1'b1;
      end
      `OPC_BRANCH: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = funct3[0];
      end
      `OPC_JAL: begin
        ctrl.reg_write  = 1'b1;
        ctrl.jump       = 1'b1;
        ctrl.result_src = riscv_core_pkg::RES_LINK;
      end
      default: ctrl = '0;
    endcase
  end

  // immediate formats
  always_comb begin
    case (opcode)
      `OPC_OP_IMM, `OPC_LOAD:
        imm = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
      `OPC_STORE:
        imm = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      `OPC_BRANCH:
        imm = {{(`XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
               i_inst[11:8], 1'b0};
      `OPC_LUI:
        imm = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
      `OPC_JAL:
        imm = {{(`XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
               i_inst[30:21], 1'b0};
      default:
        imm = '0;
    endcase
  end

  // register file, written at the edge closing write-back
  always_ff @(posedge i_riscv_decode_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_we && i_wb_rd != '0) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  // x0 stays zero through the write guard, same-cycle write bypassed
  assign rs1_data = (i_wb_we && i_wb_rd == o_rs1) ? i_wb_data : regs[o_rs1];
  assign rs2_data = (i_wb_we && i_wb_rd == o_rs2) ? i_wb_data : regs[o_rs2];

  // decode/execute register
  always_ff @(posedge i_riscv_decode_clk) begin
    o_de.pc       <= i_pc;
    o_de.rs1_data <= rs1_data;
    o_de.rs2_data <= rs2_data;
    o_de.rs1      <= o_rs1;
    o_de.rs2      <= o_rs2;
    o_de.rd       <= rd;
    o_de.imm      <= imm;
    if (!i_rst_n || i_flush || i_stall) begin
      o_de.ctrl <= '0;   // bubble
    end else begin
      o_de.ctrl <= ctrl;
    end
  end

  a_x0_zero : assert property (@(posedge i_riscv_decode_clk) disable iff (!i_rst_n)
    (o_de.rs1 == '0 |-> o_de.rs1_data == '0) and (o_de.rs2 == '0 |-> o_de.rs2_data == '0));

endmodule

`default_nettype wire

//--- rtl/riscv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_execute (
  input  logic                     i_riscv_execute_clk,
  input  logic                     i_rst_n,
  input  riscv_core_pkg::de_reg_t  i_de,
  input  riscv_core_pkg::fwd_sel_e i_fwd_a,
  input  riscv_core_pkg::fwd_sel_e i_fwd_b,
  input  riscv_core_pkg::xlen_t    i_mem_result,
  input  riscv_core_pkg::xlen_t    i_wb_result,
  output logic                     o_redirect,
  output riscv_core_pkg::xlen_t    o_target,
  output riscv_core_pkg::em_reg_t  o_em
);

  riscv_core_pkg::xlen_t op_a;
  riscv_core_pkg::xlen_t rs2_fwd;   // also the store data
  riscv_core_pkg::xlen_t op_b;
  riscv_core_pkg::xlen_t alu_res;
  logic                  equal;

  function automatic riscv_core_pkg::xlen_t fwd_mux(
    input riscv_core_pkg::fwd_sel_e sel,
    input riscv_core_pkg::xlen_t    reg_val,
    input riscv_core_pkg::xlen_t    mem_val,
    input riscv_core_pkg::xlen_t    wb_val
  );
    case (sel)
      riscv_core_pkg::FWD_MEM: return mem_val;
      riscv_core_pkg::FWD_WB:  return wb_val;
      default:                 return reg_val;
    endcase
  endfunction

  assign op_a    = fwd_mux(i_fwd_a, i_de.rs1_data, i_mem_result, i_wb_result);
  assign rs2_fwd = fwd_mux(i_fwd_b, i_de.rs2_data, i_mem_result, i_wb_result);
  assign op_b    = i_de.ctrl.use_imm ? i_de.imm : rs2_fwd;

  always_comb begin
    case (i_de.ctrl.alu_op)
      riscv_core_pkg::ALU_ADD:    alu_res = op_a + op_b;
      riscv_core_pkg::ALU_SUB:    alu_res = op_a - op_b;
      riscv_core_pkg::ALU_AND:    alu_res = op_a & op_b;
      riscv_core_pkg::ALU_OR:     alu_res = op_a | op_b;
      riscv_core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      riscv_core_pkg::ALU_PASS_B: alu_res = op_b;
      default:                    alu_res = '0;
    endcase
  end

  // branch compare on register operands, never the immediate
  assign equal      = (op_a == rs2_fwd);
  assign o_redirect = i_de.ctrl.jump | (i_de.ctrl.branch & (equal ^ i_de.ctrl.branch_ne));
  assign o_target   = i_de.pc + i_de.imm;

  // execute/memory register
  always_ff @(posedge i_riscv_execute_clk) begin
    o_em.alu_result <= alu_res;
    o_em.store_data <= rs2_fwd;
    o_em.pc_plus4   <= i_de.pc + riscv_core_pkg::xlen_t'(4);
    o_em.rd         <= i_de.rd;
    if (!i_rst_n) begin
      o_em.reg_write  <= 1'b0;
      o_em.mem_read   <= 1'b0;
      o_em.mem_write  <= 1'b0;
      o_em.result_src <= riscv_core_pkg::RES_ALU;
    end else begin
      o_em.reg_write  <= i_de.ctrl.reg_write;
      o_em.mem_read   <= i_de.ctrl.mem_read;
      o_em.mem_write  <= i_de.ctrl.mem_write;
      o_em.result_src <= i_de.ctrl.result_src;
    end
  end

  // decoder never marks a store as branch or jump
  a_no_store_redirect : assert property (@(posedge i_riscv_execute_clk) disable iff (!i_rst_n)
    !(o_redirect && i_de.ctrl.mem_write));

endmodule

`default_nettype wire

//--- rtl/riscv_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_core_defines.svh"

module riscv_fetch (
  input  logic                  i_riscv_fetch_clk,
  input  logic                  i_rst_n,
  input  logic                  i_stall,
  input  logic                  i_flush,
  input  logic                  i_redirect,
  input  riscv_core_pkg::xlen_t i_target,
  input  riscv_core_pkg::inst_t i_inst,
  output riscv_core_pkg::xlen_t o_pc,
  output riscv_core_pkg::xlen_t o_pc_d,
  output riscv_core_pkg::inst_t o_inst_d
);

  localparam riscv_core_pkg::inst_t NOP = 32'h0000_0013;  // addi x0, x0, 0

  riscv_core_pkg::xlen_t pc_next;

  // redirect wins over a load-use hold
  always_comb begin
    if (i_redirect) begin
      pc_next = i_target;
    end else if (i_stall) begin
      pc_next = o_pc;
    end else begin
      pc_next = o_pc + riscv_core_pkg::xlen_t'(4);
    end
  end

  always_ff @(posedge i_riscv_fetch_clk) begin
    if (!i_rst_n) begin
      o_pc <= `RESET_PC;
    end else begin
      o_pc <= pc_next;
    end
  end

  // fetch/decode register
  always_ff @(posedge i_riscv_fetch_clk) begin
    if (!i_stall) begin
      o_pc_d <= o_pc;
    end
    if (!i_rst_n || i_flush) begin
      o_inst_d <= NOP;      // squashed slot
    end else if (!i_stall) begin
      o_inst_d <= i_inst;
    end
  end

  a_pc_aligned : assert property (@(posedge i_riscv_fetch_clk) disable iff (!i_rst_n)
    o_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/riscv_hazard.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_hazard (
  input  riscv_core_pkg::reg_addr_t i_rs1_d,
  input  riscv_core_pkg::reg_addr_t i_rs2_d,
  input  riscv_core_pkg::reg_addr_t i_rs1_e,
  input  riscv_core_pkg::reg_addr_t i_rs2_e,
  input  riscv_core_pkg::reg_addr_t i_rd_e,
  input  riscv_core_pkg::reg_addr_t i_rd_m,
  input  riscv_core_pkg::reg_addr_t i_rd_w,
  input  logic                      i_mem_read_e,
  input  logic                      i_reg_write_m,
  input  logic                      i_reg_write_w,
  input  logic                      i_redirect,
  output logic                      o_stall,
  output logic                      o_flush_fd,
  output logic                      o_flush_de,
  output riscv_core_pkg::fwd_sel_e  o_fwd_a,
  output riscv_core_pkg::fwd_sel_e  o_fwd_b
);

  // load in execute feeding the instruction in decode
  assign o_stall = i_mem_read_e && (i_rd_e != '0) &&
                   ((i_rd_e == i_rs1_d) || (i_rd_e == i_rs2_d));

  // both younger slots are dropped on a taken branch or jal
  assign o_flush_fd = i_redirect;
  assign o_flush_de = i_redirect;

  // memory stage holds the younger value, so it wins
  always_comb begin
    o_fwd_a = riscv_core_pkg::FWD_REG;
    if (i_reg_write_m && i_rd_m != '0 && i_rd_m == i_rs1_e) begin
      o_fwd_a = riscv_core_pkg::FWD_MEM;
    end else if (i_reg_write_w && i_rd_w != '0 && i_rd_w == i_rs1_e) begin
      o_fwd_a = riscv_core_pkg::FWD_WB;
    end
  end

  always_comb begin
    o_fwd_b = riscv_core_pkg::FWD_REG;
    if (i_reg_write_m && i_rd_m != '0 && i_rd_m == i_rs2_e) begin
      o_fwd_b = riscv_core_pkg::FWD_MEM;
    end else if (i_reg_write_w && i_rd_w != '0 && i_rd_w == i_rs2_e) begin
      o_fwd_b = riscv_core_pkg::FWD_WB;
    end
  end

endmodule

`default_nettype wire

//--- rtl/riscv_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_mem_wb (
  input  logic                      i_riscv_mem_wb_clk,
  input  logic                      i_rst_n,
  input  riscv_core_pkg::em_reg_t   i_em,
  input  riscv_core_pkg::xlen_t     i_dmem_rdata,
  output riscv_core_pkg::xlen_t     o_dmem_addr,
  output riscv_core_pkg::xlen_t     o_dmem_wdata,
  output logic                      o_dmem_we,
  output logic                      o_dmem_re,
  output riscv_core_pkg::xlen_t     o_mem_result,
  output logic                      o_wb_we,
  output riscv_core_pkg::reg_addr_t o_wb_rd,
  output riscv_core_pkg::xlen_t     o_wb_data
);

  riscv_core_pkg::mw_reg_t mw_q;

  assign o_dmem_addr  = i_em.alu_result;
  assign o_dmem_wdata = i_em.store_data;
  assign o_dmem_we    = i_em.mem_write;
  assign o_dmem_re    = i_em.mem_read;

  // value forwarded from the memory stage, loads are covered by the stall
  assign o_mem_result = (i_em.result_src == riscv_core_pkg::RES_LINK) ? i_em.pc_plus4
                                                                      : i_em.alu_result;

  // memory/write-back register
  always_ff @(posedge i_riscv_mem_wb_clk) begin
    mw_q.alu_result <= i_em.alu_result;
    mw_q.load_data  <= i_dmem_rdata;
    mw_q.pc_plus4   <= i_em.pc_plus4;
    mw_q.rd         <= i_em.rd;
    if (!i_rst_n) begin
      mw_q.reg_write  <= 1'b0;
      mw_q.result_src <= riscv_core_pkg::RES_ALU;
    end else begin
      mw_q.reg_write  <= i_em.reg_write && (i_em.rd != '0);  // x0 writes dropped here
      mw_q.result_src <= i_em.result_src;
    end
  end

  always_comb begin
    case (mw_q.result_src)
      riscv_core_pkg::RES_LOAD: o_wb_data = mw_q.load_data;
      riscv_core_pkg::RES_LINK: o_wb_data = mw_q.pc_plus4;
      default:                  o_wb_data = mw_q.alu_result;
    endcase
  end

  assign o_wb_we = mw_q.reg_write;
  assign o_wb_rd = mw_q.rd;

  a_dmem_excl : assert property (@(posedge i_riscv_mem_wb_clk) disable iff (!i_rst_n)
    !(o_dmem_we && o_dmem_re));

endmodule

`default_nettype wire

//--- sim/riscv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_core_defines.svh"

module riscv_core_tb;

  localparam int IMEM_WORDS = 1024;
  localparam int DMEM_WORDS = 512;
  localparam int BASE       = 1024;  // x31 holds this
  localparam int LOAD_OFF   = 1984;
  localparam int POISON_OFF = 1992;
  localparam int DONE_OFF   = 2000;
  localparam riscv_core_pkg::xlen_t POISON_ADDR = BASE + POISON_OFF;
  localparam riscv_core_pkg::xlen_t DONE_ADDR   = BASE + DONE_OFF;

  logic                  clk;
  logic                  rst_n;
  riscv_core_pkg::inst_t imem_inst;
  riscv_core_pkg::xlen_t dmem_rdata;
  riscv_core_pkg::xlen_t imem_addr;
  riscv_core_pkg::xlen_t dmem_addr;
  riscv_core_pkg::xlen_t dmem_wdata;
  logic                  dmem_we;
  logic                  dmem_re;
  logic [8:0]            slot;

  riscv_core_pkg::inst_t imem [IMEM_WORDS];
  riscv_core_pkg::xlen_t dmem [DMEM_WORDS];
  riscv_core_pkg::xlen_t exp_mem [DMEM_WORDS];
  logic                  exp_valid [DMEM_WORDS];
  riscv_core_pkg::xlen_t gold [32];  // golden register model
  integer                seed;
  int                    n_inst;
  int                    n_checks;
  int                    n_stores;
  int                    edges;
  logic                  built;

  riscv_core i_dut (
    .i_riscv_core_clk (clk),
    .i_rst_n          (rst_n),
    .i_imem_inst      (imem_inst),
    .i_dmem_rdata     (dmem_rdata),
    .o_imem_addr      (imem_addr),
    .o_dmem_addr      (dmem_addr),
    .o_dmem_wdata     (dmem_wdata),
    .o_dmem_we        (dmem_we),
    .o_dmem_re        (dmem_re)
  );

  // same-cycle memories
  assign slot       = dmem_addr[11:3];
  assign imem_inst  = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem_re ? dmem[slot] : '0;  // data only while a read is requested

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[slot] <= dmem_wdata;
    end
  end

  function automatic riscv_core_pkg::inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic riscv_core_pkg::inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic riscv_core_pkg::inst_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], `OPC_STORE};  // sd
  endfunction

  function automatic riscv_core_pkg::inst_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  function automatic riscv_core_pkg::inst_t u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `OPC_LUI};
  endfunction

  function automatic riscv_core_pkg::inst_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
  endfunction

  function automatic riscv_core_pkg::xlen_t sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  task automatic put(input riscv_core_pkg::inst_t inst);
    imem[n_inst] = inst;
    n_inst++;
  endtask

  task automatic set_reg(input int rd, input riscv_core_pkg::xlen_t val);
    if (rd != 0) begin
      gold[rd] = val;  // x0 stays zero
    end
  endtask

  task automatic store_reg(input int rs);
    int off;
    off = 8 * n_checks;
    put(s_type(12'(off), 5'(rs), 5'd31));
    exp_mem[(BASE + off) / 8]   = gold[rs];
    exp_valid[(BASE + off) / 8] = 1'b1;
    n_checks++;
  endtask

  // two slots that a taken branch or jal must squash
  task automatic poison_pair();
    put(s_type(12'(POISON_OFF), 5'd0, 5'd31));
    put(s_type(12'(POISON_OFF), 5'd0, 5'd31));
  endtask

  // op 0..4 add sub and or xor, 5 addi, 6 lui
  task automatic alu_inst(input int op, input int rd, input int rs1, input int rs2);
    logic [11:0]           imm12;
    logic [19:0]           imm20;
    riscv_core_pkg::xlen_t a;
    riscv_core_pkg::xlen_t b;
    riscv_core_pkg::inst_t inst;
    riscv_core_pkg::xlen_t val;
    imm12 = $random(seed);
    imm20 = $random(seed);
    a = gold[rs1];
    b = gold[rs2];
    case (op)
      0:       inst = r_type(7'h00, 5'(rs2), 5'(rs1), 3'b000, 5'(rd));
      1:       inst = r_type(7'h20, 5'(rs2), 5'(rs1), 3'b000, 5'(rd));
      2:       inst = r_type(7'h00, 5'(rs2), 5'(rs1), 3'b111, 5'(rd));
      3:       inst = r_type(7'h00, 5'(rs2), 5'(rs1), 3'b110, 5'(rd));
      4:       inst = r_type(7'h00, 5'(rs2), 5'(rs1), 3'b100, 5'(rd));
      5:       inst = i_type(imm12, 5'(rs1), 3'b000, 5'(rd), `OPC_OP_IMM);
      default: inst = u_type(imm20, 5'(rd));
    endcase
    case (op)
      0:       val = a + b;
      1:       val = a - b;
      2:       val = a & b;
      3:       val = a | b;
      4:       val = a ^ b;
      5:       val = a + sext12(imm12);
      default: val = {{32{imm20[19]}}, imm20, 12'h000};
    endcase
    put(inst);
    set_reg(rd, val);
  endtask

  task automatic branch_case(input logic [2:0] funct3, input logic taken);
    logic [11:0] a;
    logic [11:0] b;
    logic        equal;
    a = $random(seed);
    equal = (funct3 == 3'b000) ? taken : !taken;
    b = equal ? a : a ^ 12'h001;
    put(i_type(a, 5'd0, 3'b000, 5'd5, `OPC_OP_IMM));
    set_reg(5, sext12(a));
    put(i_type(b, 5'd0, 3'b000, 5'd6, `OPC_OP_IMM));  // compare needs it forwarded
    set_reg(6, sext12(b));
    put(b_type(13'd12, 5'd6, 5'd5, funct3));
    if (taken) begin
      poison_pair();
    end else begin
      store_reg(5);
      store_reg(6);
    end
  endtask

  task automatic build_program();
    riscv_core_pkg::xlen_t ld_val;
    int                    prev;
    int                    prev2;
    int                    rd;
    int                    jal_pc;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0, `OPC_OP_IMM);  // addi x0, x0, i
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i]      = {32'hd0d0_0000 | 32'(i), ~32'(i)};
      exp_mem[i]   = '0;
      exp_valid[i] = 1'b0;
    end
    for (int r = 0; r < 32; r++) begin
      gold[r] = '0;
    end
    n_inst   = 0;
    n_checks = 0;
    put(i_type(12'(BASE), 5'd0, 3'b000, 5'd31, `OPC_OP_IMM));
    set_reg(31, BASE);
    for (int r = 1; r <= 8; r++) begin
      alu_inst(6, r, 0, 0);
      alu_inst(5, r, r, 0);  // leans on the lui right before
    end
    prev  = 8;
    prev2 = 7;
    for (int i = 0; i < 30; i++) begin
      rd = 1 + $unsigned($random(seed)) % 8;
      alu_inst($unsigned($random(seed)) % 7, rd, prev, prev2);
      if (i % 3 == 2) begin
        store_reg(rd);
      end
      prev2 = prev;
      prev  = rd;
    end
    for (int r = 1; r <= 8; r++) begin
      store_reg(r);
    end
    alu_inst(5, 0, 1, 0);
    alu_inst(0, 0, 1, 2);
    store_reg(0);
    ld_val[63:32] = $random(seed);
    ld_val[31:0]  = $random(seed);
    dmem[(BASE + LOAD_OFF) / 8] = ld_val;
    put(i_type(12'(LOAD_OFF), 5'd31, 3'b011, 5'd10, `OPC_LOAD));
    set_reg(10, ld_val);
    alu_inst(0, 11, 10, 3);  // load-use pair
    store_reg(11);
    store_reg(10);
    branch_case(3'b000, 1'b1);
    branch_case(3'b000, 1'b0);
    branch_case(3'b001, 1'b1);
    branch_case(3'b001, 1'b0);
    jal_pc = n_inst * 4;
    put(j_type(21'd12, 5'd9));
    poison_pair();
    set_reg(9, riscv_core_pkg::xlen_t'(jal_pc + 4));
    store_reg(9);
    put(s_type(12'(DONE_OFF), 5'd0, 5'd31));
    put(j_type(21'd0, 5'd0));  // park
  endtask

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  initial begin
    rst_n    = 1'b0;
    built    = 1'b0;
    n_stores = 0;
    edges    = 0;
    seed     = 32'h421c_303a;
    build_program();
    built = 1'b1;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  end

  always @(posedge clk) begin
    edges <= edges + 1;
    if (rst_n && dmem_we && exp_valid[slot]) begin
      n_stores <= n_stores + 1;
    end
    if (rst_n && dmem_we && dmem_addr == DONE_ADDR) begin
      if (n_stores == n_checks) begin
        $display("All tests passed");
        $finish;
      end else begin
        $display("done store reached with %0d of %0d check stores seen", n_stores, n_checks);
        $display("Some tests failed");
        $fatal(1);
      end
    end
  end

  a_store_value : assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we && exp_valid[slot] |-> dmem_wdata == exp_mem[slot])
    else begin
      $display("Mismatch o_dmem_wdata at 0x%h: 0x%h, expected 0x%h", $sampled(dmem_addr),
               $sampled(dmem_wdata), exp_mem[$sampled(slot)]);
      $display("Some tests failed");
      $fatal(1);
    end

  a_store_known : assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> dmem_addr < DMEM_WORDS * 8 &&
      (exp_valid[slot] || dmem_addr == DONE_ADDR || dmem_addr == POISON_ADDR))
    else begin
      $display("store to an address that no check expects: 0x%h", $sampled(dmem_addr));
      $display("Some tests failed");
      $fatal(1);
    end

  a_no_poison : assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> dmem_addr != POISON_ADDR)
    else begin
      $display("a squashed store reached the poison slot, branch or jal flush is wrong");
      $display("Some tests failed");
      $fatal(1);
    end

  // first edge only loads the reset values
  a_quiet_reset : assert property (@(posedge clk)
    !rst_n && edges > 0 |-> !dmem_we && !dmem_re)
    else begin
      $display("Mismatch o_dmem_we/o_dmem_re in reset: 0x%h/0x%h, expected 0x0/0x0",
               $sampled(dmem_we), $sampled(dmem_re));
      $display("Some tests failed");
      $fatal(1);
    end

  a_no_early_read : assert property (@(posedge clk) disable iff (!rst_n)
    n_stores == 0 |-> !dmem_re)
    else begin
      $display("Mismatch o_dmem_re before the first store: 0x%h, expected 0x0",
               $sampled(dmem_re));
      $display("Some tests failed");
      $fatal(1);
    end

  initial begin
    wait (built);
    repeat (n_inst * 4 + 60) @(posedge clk);
    $display("timeout: the program did not reach its done store in %0d cycles", n_inst * 4 + 60);
    $display("Some tests failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/riscv_core_pkg.sv
rtl/riscv_fetch.sv
rtl/riscv_decode.sv
rtl/riscv_execute.sv
rtl/riscv_mem_wb.sv
rtl/riscv_hazard.sv
rtl/riscv_core.sv
sim/riscv_core_tb.sv
